//--- common/fifo_demo_pkg.sv
`default_nettype none

package fifo_demo_pkg;

    // frame geometry
    localparam int FRAME_LEN  = 12;
    localparam int PAGE_COUNT = 3;

    // byte index counter, also the low nibble of every pattern byte
    localparam int IDX_W = 4;
    localparam logic [IDX_W-1:0] IDX_END = IDX_W'(FRAME_LEN);

    // page select
    localparam int PAGE_W = 2;
    localparam logic [PAGE_W-1:0] PAGE_LAST = PAGE_W'(PAGE_COUNT - 1);

    // fifo sizing, depth must hold one whole frame
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;
    localparam int FIFO_CW    = FIFO_AW + 1;
    localparam logic [FIFO_CW-1:0] FIFO_FULL_CNT = FIFO_CW'(FIFO_DEPTH);

    // key debounce, short for simulation; raise for the board
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int DEBOUNCE_W      = 4;
    localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_LAST = DEBOUNCE_W'(DEBOUNCE_CYCLES - 1);

    // idle gap after a read
    localparam int SETTLE_CYCLES = 2;
    localparam int SETTLE_W      = 1;
    localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SETTLE_CYCLES - 1);

    // one frame seen as bytes (reader side) or as led pages (display side)
    typedef union packed {
        logic [0:FRAME_LEN-1][7:0]   bytes;
        logic [0:PAGE_COUNT-1][31:0] words;
    } frame_u;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        SETTLE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/key_filter.sv
`timescale 1ns/1ns
`default_nettype none

module key_filter (
    input  wire  sys_clk,
    input  wire  rst,
    input  logic key_n,
    output logic press
);

    logic sync_meta;
    logic sync_key;
    logic stable;
    logic [fifo_demo_pkg::DEBOUNCE_W-1:0] timer;

    // two-flop synchronizer, keys idle high
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            sync_meta <= 1'b1;
            sync_key  <= 1'b1;
        end else begin
            sync_meta <= key_n;
            sync_key  <= sync_meta;
        end
    end

    // accept a new level only after it has held for the full window
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            stable <= 1'b1;
            timer  <= '0;
            press  <= 1'b0;
        end else begin
            press <= 1'b0;
            if (sync_key == stable) begin
                // glitch ended or no change, restart the window
                timer <= '0;
            end else if (timer == fifo_demo_pkg::DEBOUNCE_LAST) begin
                stable <= sync_key;
                timer  <= '0;
                // only the falling edge of the accepted level counts as a press
                press  <= ~sync_key;
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/demo_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module demo_ctrl (
    input  wire  sys_clk,
    input  wire  rst,
    input  logic load_press,
    input  logic fifo_full,
    input  logic write_done,
    input  logic read_done,
    output logic write_start,
    output logic read_start
);

    fifo_demo_pkg::ctrl_state_e state;
    logic [fifo_demo_pkg::SETTLE_W-1:0] settle_cnt;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state       <= fifo_demo_pkg::IDLE;
            settle_cnt  <= '0;
            write_start <= 1'b0;
            read_start  <= 1'b0;
        end else begin
            write_start <= 1'b0;
            read_start  <= 1'b0;
            case (state)
                fifo_demo_pkg::IDLE: begin
                    // loads are only taken here, presses elsewhere are dropped
                    if (load_press && !fifo_full) begin
                        write_start <= 1'b1;
                        state       <= fifo_demo_pkg::WRITE;
                    end
                end
                fifo_demo_pkg::WRITE: begin
                    if (write_done) begin
                        read_start <= 1'b1;
                        state      <= fifo_demo_pkg::READ;
                    end
                end
                fifo_demo_pkg::READ: begin
                    if (read_done) begin
                        settle_cnt <= '0;
                        state      <= fifo_demo_pkg::SETTLE;
                    end
                end
                fifo_demo_pkg::SETTLE: begin
                    if (settle_cnt == fifo_demo_pkg::SETTLE_LAST) begin
                        state <= fifo_demo_pkg::IDLE;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                default: state <= fifo_demo_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fifo/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo (
    input  wire        sys_clk,
    input  wire        rst,
    input  logic       wr_en,
    input  logic [7:0] din,
    input  logic       rd_en,
    output logic [7:0] dout,
    output logic       full,
    output logic       empty
);

    logic [7:0] mem [fifo_demo_pkg::FIFO_DEPTH];
    logic [fifo_demo_pkg::FIFO_AW-1:0] wr_ptr;
    logic [fifo_demo_pkg::FIFO_AW-1:0] rd_ptr;
    logic [fifo_demo_pkg::FIFO_CW-1:0] count;
    logic do_wr;
    logic do_rd;

    assign full  = (count == fifo_demo_pkg::FIFO_FULL_CNT);
    assign empty = (count == '0);

    // overflow writes and underflow reads are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read port, dout follows rd_en by one cycle
    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- fifo/fifo_writer.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_writer (
    input  wire        sys_clk,
    input  wire        rst,
    input  logic       write_start,
    output logic       wr_en,
    output logic [7:0] wr_data,
    output logic       write_done
);

    // index of the next byte to put out
    logic [fifo_demo_pkg::IDX_W-1:0] idx;
    // survives across frames, wraps at 16
    logic [3:0] frame_num;
    logic last_sent;

    assign last_sent = wr_en && (idx == fifo_demo_pkg::IDX_END);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_en      <= 1'b0;
            write_done <= 1'b0;
            idx        <= '0;
            frame_num  <= '0;
        end else begin
            write_done <= 1'b0;
            if (write_start) begin
                wr_en <= 1'b1;
                idx   <= 1'b1;
            end else if (last_sent) begin
                wr_en      <= 1'b0;
                write_done <= 1'b1;
                frame_num  <= frame_num + 1'b1;
            end else if (wr_en) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // pattern byte: frame number high, byte index low
    always_ff @(posedge sys_clk) begin
        if (write_start) begin
            wr_data <= {frame_num, 4'h0};
        end else if (wr_en && !last_sent) begin
            wr_data <= {frame_num, idx};
        end
    end

endmodule

`default_nettype wire

//--- fifo/fifo_reader.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_reader (
    input  wire                   sys_clk,
    input  wire                   rst,
    input  logic                  read_start,
    output logic                  rd_en,
    input  logic [7:0]            rd_data,
    output fifo_demo_pkg::frame_u frame,
    output logic                  read_done
);

    logic [fifo_demo_pkg::IDX_W-1:0] idx;
    logic last_issue;
    // rd_data is valid the cycle after rd_en
    logic data_valid;
    logic data_last;
    logic frame_ready;
    fifo_demo_pkg::frame_u work;

    assign last_issue = rd_en && (idx == fifo_demo_pkg::IDX_END);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            rd_en       <= 1'b0;
            idx         <= '0;
            data_valid  <= 1'b0;
            data_last   <= 1'b0;
            frame_ready <= 1'b0;
            read_done   <= 1'b0;
            frame       <= '0;
        end else begin
            if (read_start) begin
                rd_en <= 1'b1;
                idx   <= 1'b1;
            end else if (last_issue) begin
                rd_en <= 1'b0;
            end else if (rd_en) begin
                idx <= idx + 1'b1;
            end
            data_valid  <= rd_en;
            data_last   <= last_issue;
            frame_ready <= data_last;
            read_done   <= frame_ready;
            // publish only whole frames
            if (frame_ready) begin
                frame <= work;
            end
        end
    end

    // first byte ends up in the most significant slot
    always_ff @(posedge sys_clk) begin
        if (data_valid) begin
            work.bytes <= {work.bytes[1:fifo_demo_pkg::FRAME_LEN-1], rd_data};
        end
    end

endmodule

`default_nettype wire

//--- led/led_pager.sv
`timescale 1ns/1ns
`default_nettype none

module led_pager (
    input  wire                   sys_clk,
    input  wire                   rst,
    input  logic                  page_press,
    input  fifo_demo_pkg::frame_u frame,
    output logic [31:0]           led,
    output logic [3:0]            lec
);

    logic [fifo_demo_pkg::PAGE_W-1:0] page;

    // page wraps after the last page of the frame
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            page <= '0;
        end else if (page_press) begin
            if (page == fifo_demo_pkg::PAGE_LAST) begin
                page <= '0;
            end else begin
                page <= page + 1'b1;
            end
        end
    end

    // registered display outputs
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            lec <= 4'b0001;
        end else begin
            led <= frame.words[page];
            // one lamp per page, bit 3 never lit
            lec <= 4'b0001 << page;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fifo_demo_top.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_demo_top (
    input  wire         sys_clk,
    input  wire         rst,
    input  logic        key_load_n,
    input  logic        key_page_n,
    output logic [31:0] led,
    output logic [3:0]  lec
);

    logic load_press;
    logic page_press;
    logic write_start;
    logic read_start;
    logic write_done;
    logic read_done;
    logic wr_en;
    logic rd_en;
    logic [7:0] wr_data;
    logic [7:0] rd_data;
    logic fifo_full;
    fifo_demo_pkg::frame_u frame;

    key_filter u_key_load (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key_n   (key_load_n),
        .press   (load_press)
    );

    key_filter u_key_page (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key_n   (key_page_n),
        .press   (page_press)
    );

    demo_ctrl u_demo_ctrl (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .load_press  (load_press),
        .fifo_full   (fifo_full),
        .write_done  (write_done),
        .read_done   (read_done),
        .write_start (write_start),
        .read_start  (read_start)
    );

    fifo_writer u_fifo_writer (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .write_start (write_start),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .write_done  (write_done)
    );

    sync_fifo u_sync_fifo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .din     (wr_data),
        .rd_en   (rd_en),
        .dout    (rd_data),
        .full    (fifo_full),
        .empty   ()
    );

    fifo_reader u_fifo_reader (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .read_start (read_start),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .frame      (frame),
        .read_done  (read_done)
    );

    led_pager u_led_pager (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .page_press (page_press),
        .frame      (frame),
        .led        (led),
        .lec        (lec)
    );

endmodule

`default_nettype wire

//--- verification/fifo_demo_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_demo_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int HOLD_CYCLES  = 3 * fifo_demo_pkg::DEBOUNCE_CYCLES;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES;
    localparam int LED_LIMIT    = 200;
    localparam int PAGE_BYTES   = fifo_demo_pkg::FRAME_LEN / fifo_demo_pkg::PAGE_COUNT;
    localparam int GLITCH_COUNT = 8;
    localparam int GLITCH_MAX   = fifo_demo_pkg::DEBOUNCE_CYCLES - 1;
    localparam int GAP_MAX      = 8;
    // one full round of frame numbers
    localparam int WRAP_LOADS   = 16;

    // cycle budget per test, summed for the watchdog
    localparam int BUDGET_RESET  = 10;
    localparam int BUDGET_PRESS  = PRESS_CYCLES + LED_LIMIT;
    localparam int BUDGET_GLITCH = 2 * GLITCH_COUNT * (GLITCH_MAX + GAP_MAX + 1)
                                   + 4 * fifo_demo_pkg::DEBOUNCE_CYCLES;
    localparam int WATCHDOG_CYCLES = BUDGET_RESET + BUDGET_PRESS + 3 * BUDGET_PRESS
                                     + 2 * BUDGET_PRESS + BUDGET_GLITCH
                                     + WRAP_LOADS * BUDGET_PRESS + 500;

    logic        sys_clk;
    logic        rst;
    logic        key_load_n;
    logic        key_page_n;
    logic [31:0] led;
    logic [3:0]  lec;

    int          errors;
    int          checks;
    int          tests_run;
    integer      seed;
    // reference state of the demo
    logic [3:0]  next_frame;
    logic [3:0]  shown_frame;
    int          page_sel;

    fifo_demo_top u_dut (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .key_load_n (key_load_n),
        .key_page_n (key_page_n),
        .led        (led),
        .lec        (lec)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // byte i of frame n is {n, i}, pages are 4-byte slices, byte 0 on top
    function automatic logic [31:0] expected_word(input logic [3:0] frame_num, input int page);
        logic [31:0] word;
        logic [3:0]  idx;
        int          b;
        word = '0;
        for (b = 0; b < PAGE_BYTES; b++) begin
            idx  = 4'(page * PAGE_BYTES + b);
            word = {word[23:0], frame_num, idx};
        end
        return word;
    endfunction

    // one lamp per page, lamp 3 stays dark
    function automatic logic [3:0] expected_lec(input int page);
        logic [3:0] lamps;
        case (page)
            0:       lamps = 4'b0001;
            1:       lamps = 4'b0010;
            2:       lamps = 4'b0100;
            default: lamps = 4'b0000;
        endcase
        return lamps;
    endfunction

    task automatic check_led(input logic [31:0] expected, input string what);
        checks++;
        if (led !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, led expected %08h, got %08h",
                     $time, what, expected, led);
        end
    endtask

    task automatic check_lec(input logic [3:0] expected, input string what);
        checks++;
        if (lec !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, lec expected %04b, got %04b",
                     $time, what, expected, lec);
        end
    endtask

    // poll led on falling edges, where the registered outputs are settled
    task automatic wait_led(input logic [31:0] expected, input string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        checks++;
        while (!seen && n < LED_LIMIT) begin
            @(negedge sys_clk);
            if (led === expected) begin
                seen = 1'b1;
            end
            n++;
        end
        if (!seen) begin
            errors++;
            $display("timeout at %0t ns: %s, led never showed %08h within %0d cycles (last %08h)",
                     $time, what, expected, LED_LIMIT, led);
        end
    endtask

    task automatic press_key(input bit page_key);
        @(negedge sys_clk);
        if (page_key) begin
            key_page_n = 1'b0;
        end else begin
            key_load_n = 1'b0;
        end
        repeat (HOLD_CYCLES) @(negedge sys_clk);
        key_page_n = 1'b1;
        key_load_n = 1'b1;
        repeat (HOLD_CYCLES) @(negedge sys_clk);
    endtask

    task automatic glitch_key(input bit page_key, input int len, input int gap);
        @(negedge sys_clk);
        if (page_key) begin
            key_page_n = 1'b0;
        end else begin
            key_load_n = 1'b0;
        end
        repeat (len) @(negedge sys_clk);
        key_page_n = 1'b1;
        key_load_n = 1'b1;
        repeat (gap) @(negedge sys_clk);
    endtask

    task automatic load_frame(input string what);
        press_key(1'b0);
        shown_frame = next_frame;
        next_frame  = next_frame + 4'd1;
        wait_led(expected_word(shown_frame, page_sel), what);
        check_lec(expected_lec(page_sel), what);
    endtask

    task automatic next_page(input string what);
        press_key(1'b1);
        page_sel = (page_sel + 1) % fifo_demo_pkg::PAGE_COUNT;
        wait_led(expected_word(shown_frame, page_sel), what);
        check_lec(expected_lec(page_sel), what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic after_reset();
        int start_err;
        start_err = errors;
        @(negedge sys_clk);
        check_lec(expected_lec(0), "after reset");
        check_led(32'h0, "after reset");
        report_test("after_reset", start_err);
    endtask

    task automatic first_load();
        int start_err;
        start_err = errors;
        load_frame("first load");
        report_test("first_load", start_err);
    endtask

    task automatic page_cycle();
        int start_err;
        int i;
        start_err = errors;
        for (i = 0; i < fifo_demo_pkg::PAGE_COUNT; i++) begin
            next_page("page step");
        end
        report_test("page_cycle", start_err);
    endtask

    task automatic second_load_keeps_page();
        int start_err;
        start_err = errors;
        next_page("select page 1");
        load_frame("second load");
        report_test("second_load_keeps_page", start_err);
    endtask

    task automatic glitch_rejection();
        int start_err;
        int i;
        int len;
        int gap;
        start_err = errors;
        for (i = 0; i < GLITCH_COUNT; i++) begin
            len = 1 + ($unsigned($random(seed)) % GLITCH_MAX);
            gap = 2 + ($unsigned($random(seed)) % (GAP_MAX - 1));
            glitch_key(1'b0, len, gap);
            len = 1 + ($unsigned($random(seed)) % GLITCH_MAX);
            gap = 2 + ($unsigned($random(seed)) % (GAP_MAX - 1));
            glitch_key(1'b1, len, gap);
        end
        // long enough for any late press to reach the display
        repeat (4 * fifo_demo_pkg::DEBOUNCE_CYCLES) @(negedge sys_clk);
        check_led(expected_word(shown_frame, page_sel), "after glitches");
        check_lec(expected_lec(page_sel), "after glitches");
        report_test("glitch_rejection", start_err);
    endtask

    task automatic frame_wrap();
        int start_err;
        int i;
        start_err = errors;
        for (i = 0; i < WRAP_LOADS; i++) begin
            load_frame("wrap load");
        end
        report_test("frame_wrap", start_err);
    endtask

    initial begin
        seed        = 67398;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        next_frame  = 4'd0;
        shown_frame = 4'd0;
        page_sel    = 0;
        rst         = 1'b1;
        key_load_n  = 1'b1;
        key_page_n  = 1'b1;
        repeat (5) @(negedge sys_clk);
        rst = 1'b0;

        after_reset();
        first_load();
        page_cycle();
        second_load_keeps_page();
        glitch_rejection();
        frame_wrap();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/fifo_demo_pkg.sv
rtl/key_filter.sv
rtl/demo_ctrl.sv
fifo/sync_fifo.sv
fifo/fifo_writer.sv
fifo/fifo_reader.sv
led/led_pager.sv
rtl/fifo_demo_top.sv
verification/fifo_demo_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
TOP        ?= fifo_demo_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
